// File: verilog/cmd_params.svh
`ifndef CMD_PARAMS_SVH
`define CMD_PARAMS_SVH

// Queue sizing, depth is 2**CMD_FIFO_AW words
`define CMD_FIFO_AW    3
`define CMD_WORD_W     32      // Command and response word width
`define CMD_REG_CNT    4       // Working registers
`define CMD_VAL_W      16      // Register value and immediate width

// Command word fields
`define CMD_OPC_HI     31
`define CMD_OPC_LO     28
`define CMD_DST_HI     27
`define CMD_DST_LO     26
`define CMD_SRC_HI     25
`define CMD_SRC_LO     24
`define CMD_IMM_HI     15
`define CMD_IMM_LO     0

// Response word fields, bits 25..19 read as zero
`define RSP_OPC_HI     31
`define RSP_OPC_LO     28
`define RSP_DST_HI     27
`define RSP_DST_LO     26
`define RSP_ILL_BIT    18
`define RSP_CRY_BIT    17
`define RSP_ZERO_BIT   16
`define RSP_VAL_HI     15
`define RSP_VAL_LO     0

`endif

// File: verilog/cmd_pkg.sv
`include "cmd_params.svh"

package cmd_pkg;

   // Command or response word as carried by both queues
   typedef logic [`CMD_WORD_W-1:0] cmd_word_t;

   // Register contents, also the immediate field
   typedef logic [`CMD_VAL_W-1:0] cmd_value_t;

   typedef logic [$clog2(`CMD_REG_CNT)-1:0] cmd_reg_idx_t;   // Dest or source select

   // Opcode field, codes above OP_READ are illegal
   typedef enum logic [3:0] {
      OP_LOAD = 4'd0,   // dest = imm
      OP_ADD  = 4'd1,   // dest = dest + imm
      OP_SUB  = 4'd2,   // dest = dest - imm
      OP_AND  = 4'd3,   // dest = dest & src
      OP_OR   = 4'd4,   // dest = dest | src
      OP_XOR  = 4'd5,   // dest = dest ^ src
      OP_SHL  = 4'd6,   // dest = dest << imm[3:0]
      OP_READ = 4'd7    // Report dest only
   } cmd_opcode_e;

endpackage

// File: verilog/fifo.sv
`timescale 1ns/10ps
`include "cmd_params.svh"

// Circular buffer with rts/rtr on both sides and a registered output word
module fifo #(
   parameter int BUF_WIDTH = `CMD_FIFO_AW,   // Pointer bits
   parameter int DATA_SIZE = `CMD_WORD_W     // Word width
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [DATA_SIZE-1:0] inp_data,    // Word to push
   input  logic                 inp_rts,     // Writer has a word
   output logic                 inp_rtr,     // Room for a word
   output logic                 out_rts,     // Word available
   input  logic                 out_rtr,     // Reader takes a word
   output logic [DATA_SIZE-1:0] out_data     // Popped word, valid the cycle after the pop
);

   localparam int BUF_SIZE = 1 << BUF_WIDTH;

   logic [BUF_WIDTH:0]   count;                   // One extra bit to tell full from empty
   logic [BUF_WIDTH-1:0] rd_ptr;
   logic [BUF_WIDTH-1:0] wr_ptr;
   logic [DATA_SIZE-1:0] buf_mem [BUF_SIZE];
   logic                 push;
   logic                 pop;

   // Handshakes follow the fill level only
   always_comb
   begin
      out_rts = (count != '0);
      inp_rtr = (count != BUF_SIZE[BUF_WIDTH:0]);
   end

   assign push = inp_rts && inp_rtr;
   assign pop  = out_rts && out_rtr;

   // Simultaneous push and pop leaves the count alone
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         count <= '0;
      else if (push && !pop)
         count <= count + 1'b1;
      else if (pop && !push)
         count <= count - 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Storage, no reset
   always_ff @(posedge clk)
   begin
      if (push)
         buf_mem[wr_ptr] <= inp_data;
   end

   // Output word held until the next pop
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         out_data <= '0;
      else if (pop)
         out_data <= buf_mem[rd_ptr];
   end

   a_count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      count <= BUF_SIZE[BUF_WIDTH:0])
      else $error("fifo count above depth");

   // An empty buffer never moves its read side
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      (count == '0) |=> $stable(rd_ptr))
      else $error("fifo popped while empty");

endmodule

// File: verilog/cmd_decode.sv
`timescale 1ns/10ps
`include "cmd_params.svh"

// Pops one command at a time and splits it into fields
module cmd_decode (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   advance,       // Pipeline may move
   input  logic                   cq_rts,        // Command queue not empty
   input  cmd_pkg::cmd_word_t     cq_data,       // Registered queue output
   output logic                   cq_rtr,        // Pop strobe
   output logic                   dec_valid,
   output cmd_pkg::cmd_opcode_e   dec_opcode,
   output cmd_pkg::cmd_reg_idx_t  dec_dest,
   output cmd_pkg::cmd_reg_idx_t  dec_src,
   output cmd_pkg::cmd_value_t    dec_imm,
   output logic                   dec_illegal    // Opcode outside the known set
);

   logic       pend;                             // Popped, word not yet captured
   logic [3:0] raw_opc;

   assign raw_opc = cq_data[`CMD_OPC_HI:`CMD_OPC_LO];

   // Only one pop in flight since the word shows up a cycle late
   assign cq_rtr = advance && !pend && cq_rts;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pend      <= 1'b0;
         dec_valid <= 1'b0;
      end
      else if (advance)
      begin
         pend      <= cq_rtr;                    // Clears as the word is captured
         dec_valid <= pend;
      end
   end

   // Field split, payload only
   always_ff @(posedge clk)
   begin
      if (advance && pend)
      begin
         dec_opcode  <= cmd_pkg::cmd_opcode_e'(raw_opc);   // Unknown codes kept for echo
         dec_dest    <= cq_data[`CMD_DST_HI:`CMD_DST_LO];
         dec_src     <= cq_data[`CMD_SRC_HI:`CMD_SRC_LO];
         dec_imm     <= cq_data[`CMD_IMM_HI:`CMD_IMM_LO];
         dec_illegal <= (raw_opc > cmd_pkg::OP_READ);
      end
   end

   // A pop is always followed by a cycle without one
   a_one_pop_pending: assert property (@(posedge clk) disable iff (!rst_n)
      cq_rtr |=> !cq_rtr)
      else $error("cmd_decode second pop while pending");

endmodule

// File: verilog/alu_execute.sv
`timescale 1ns/10ps
`include "cmd_params.svh"

// Working registers and the ALU, one command per advancing valid cycle
module alu_execute (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   advance,
   input  logic                   dec_valid,
   input  cmd_pkg::cmd_opcode_e   dec_opcode,
   input  cmd_pkg::cmd_reg_idx_t  dec_dest,
   input  cmd_pkg::cmd_reg_idx_t  dec_src,
   input  cmd_pkg::cmd_value_t    dec_imm,
   input  logic                   dec_illegal,
   output logic                   ex_valid,
   output cmd_pkg::cmd_opcode_e   ex_opcode,
   output cmd_pkg::cmd_reg_idx_t  ex_dest,
   output cmd_pkg::cmd_value_t    ex_value,      // Result, or dest for READ
   output logic                   ex_zero,
   output logic                   ex_carry,
   output logic                   ex_illegal
);

   cmd_pkg::cmd_value_t regs [`CMD_REG_CNT];
   cmd_pkg::cmd_value_t res;                     // Next dest value
   logic                res_carry;
   logic                wr_en;                   // Write back this cycle

   always_comb
   begin
      logic [`CMD_VAL_W:0]     ar_wide;          // Sum or difference with carry bit
      logic [2*`CMD_VAL_W-1:0] shl_wide;         // Shift with room for lost bits
      cmd_pkg::cmd_value_t     cur;
      cmd_pkg::cmd_value_t     srcv;
      cur       = regs[dec_dest];
      srcv      = regs[dec_src];
      ar_wide   = '0;
      shl_wide  = {{`CMD_VAL_W{1'b0}}, cur} << dec_imm[3:0];
      res       = '0;
      res_carry = 1'b0;
      case (dec_opcode)
         cmd_pkg::OP_LOAD: res = dec_imm;
         cmd_pkg::OP_ADD:
         begin
            ar_wide   = {1'b0, cur} + {1'b0, dec_imm};
            res       = ar_wide[`CMD_VAL_W-1:0];
            res_carry = ar_wide[`CMD_VAL_W];     // Carry out
         end
         cmd_pkg::OP_SUB:
         begin
            ar_wide   = {1'b0, cur} - {1'b0, dec_imm};
            res       = ar_wide[`CMD_VAL_W-1:0];
            res_carry = ar_wide[`CMD_VAL_W];     // Borrow
         end
         cmd_pkg::OP_AND: res = cur & srcv;
         cmd_pkg::OP_OR:  res = cur | srcv;
         cmd_pkg::OP_XOR: res = cur ^ srcv;
         cmd_pkg::OP_SHL:
         begin
            res       = shl_wide[`CMD_VAL_W-1:0];
            res_carry = shl_wide[`CMD_VAL_W];    // Last bit shifted out, zero for no shift
         end
         cmd_pkg::OP_READ: res = cur;
         default: res = '0;                      // Unknown code reports zero
      endcase
      if (dec_illegal)
      begin
         res       = '0;
         res_carry = 1'b0;
      end
   end

   assign wr_en = advance && dec_valid && !dec_illegal && (dec_opcode != cmd_pkg::OP_READ);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `CMD_REG_CNT; i++)
            regs[i] <= '0;
      end
      else if (wr_en)
         regs[dec_dest] <= res;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ex_valid <= 1'b0;
      else if (advance)
         ex_valid <= dec_valid;
   end

   // Result register, payload only
   always_ff @(posedge clk)
   begin
      if (advance && dec_valid)
      begin
         ex_opcode  <= dec_opcode;
         ex_dest    <= dec_dest;
         ex_value   <= res;
         ex_zero    <= (res == '0);             // Set for illegal too, value is zero
         ex_carry   <= res_carry;
         ex_illegal <= dec_illegal;
      end
   end

endmodule

// File: verilog/result_pack.sv
`timescale 1ns/10ps
`include "cmd_params.svh"

// Builds the response word and strobes it into the response queue
module result_pack (
   input  logic                   advance,       // Response queue has room
   input  logic                   ex_valid,
   input  cmd_pkg::cmd_opcode_e   ex_opcode,
   input  cmd_pkg::cmd_reg_idx_t  ex_dest,
   input  cmd_pkg::cmd_value_t    ex_value,
   input  logic                   ex_zero,
   input  logic                   ex_carry,
   input  logic                   ex_illegal,
   output logic                   rq_push,       // Response queue inp_rts
   output cmd_pkg::cmd_word_t     rq_data
);

   // Push only on a cycle the whole pipeline moves
   assign rq_push = ex_valid && advance;

   always_comb
   begin
      rq_data = '0;                              // Spare bits read as zero
      rq_data[`RSP_OPC_HI:`RSP_OPC_LO] = ex_opcode;   // Opcode echoed even when unknown
      rq_data[`RSP_DST_HI:`RSP_DST_LO] = ex_dest;
      rq_data[`RSP_ILL_BIT]            = ex_illegal;
      rq_data[`RSP_CRY_BIT]            = ex_carry;
      rq_data[`RSP_ZERO_BIT]           = ex_zero;
      rq_data[`RSP_VAL_HI:`RSP_VAL_LO] = ex_value;
   end

endmodule

// File: verilog/cmd_proc_top.sv
`timescale 1ns/10ps
`include "cmd_params.svh"

// Command queue, decode, execute, pack, response queue
module cmd_proc_top (
   input  logic                clk,
   input  logic                rst_n,
   input  cmd_pkg::cmd_word_t  cmd_data,
   input  logic                cmd_rts,
   output logic                cmd_rtr,
   input  logic                rsp_rtr,
   output cmd_pkg::cmd_word_t  rsp_data,
   output logic                rsp_rts
);

   // Command queue to decode
   logic                   cq_rts;
   logic                   cq_rtr;
   cmd_pkg::cmd_word_t     cq_data;

   // Decode to execute
   logic                   dec_valid;
   cmd_pkg::cmd_opcode_e   dec_opcode;
   cmd_pkg::cmd_reg_idx_t  dec_dest;
   cmd_pkg::cmd_reg_idx_t  dec_src;
   cmd_pkg::cmd_value_t    dec_imm;
   logic                   dec_illegal;

   // Execute to pack
   logic                   ex_valid;
   cmd_pkg::cmd_opcode_e   ex_opcode;
   cmd_pkg::cmd_reg_idx_t  ex_dest;
   cmd_pkg::cmd_value_t    ex_value;
   logic                   ex_zero;
   logic                   ex_carry;
   logic                   ex_illegal;

   // Pack to response queue
   logic                   rq_push;
   cmd_pkg::cmd_word_t     rq_data;
   logic                   rq_rtr;
   logic                   advance;

   assign advance = rq_rtr;                      // Full response queue stalls every stage

   fifo #(.BUF_WIDTH(`CMD_FIFO_AW), .DATA_SIZE(`CMD_WORD_W)) cmd_fifo (
      .clk(clk), .rst_n(rst_n),
      .inp_data(cmd_data), .inp_rts(cmd_rts), .inp_rtr(cmd_rtr),
      .out_rts(cq_rts), .out_rtr(cq_rtr), .out_data(cq_data)
   );

   cmd_decode u_decode (
      .clk(clk), .rst_n(rst_n), .advance(advance),
      .cq_rts(cq_rts), .cq_data(cq_data), .cq_rtr(cq_rtr),
      .dec_valid(dec_valid), .dec_opcode(dec_opcode), .dec_dest(dec_dest),
      .dec_src(dec_src), .dec_imm(dec_imm), .dec_illegal(dec_illegal)
   );

   alu_execute u_execute (
      .clk(clk), .rst_n(rst_n), .advance(advance),
      .dec_valid(dec_valid), .dec_opcode(dec_opcode), .dec_dest(dec_dest),
      .dec_src(dec_src), .dec_imm(dec_imm), .dec_illegal(dec_illegal),
      .ex_valid(ex_valid), .ex_opcode(ex_opcode), .ex_dest(ex_dest),
      .ex_value(ex_value), .ex_zero(ex_zero), .ex_carry(ex_carry),
      .ex_illegal(ex_illegal)
   );

   result_pack u_pack (
      .advance(advance), .ex_valid(ex_valid), .ex_opcode(ex_opcode),
      .ex_dest(ex_dest), .ex_value(ex_value), .ex_zero(ex_zero),
      .ex_carry(ex_carry), .ex_illegal(ex_illegal),
      .rq_push(rq_push), .rq_data(rq_data)
   );

   fifo #(.BUF_WIDTH(`CMD_FIFO_AW), .DATA_SIZE(`CMD_WORD_W)) rsp_fifo (
      .clk(clk), .rst_n(rst_n),
      .inp_data(rq_data), .inp_rts(rq_push), .inp_rtr(rq_rtr),
      .out_rts(rsp_rts), .out_rtr(rsp_rtr), .out_data(rsp_data)
   );

endmodule

// File: tests/cmd_proc_tb.sv
`timescale 1ns/10ps

// Trace driven testbench for the command processor
module cmd_proc_tb;

   localparam int MAX_RECS = 64;

   logic               clk;
   logic               rst_n;
   cmd_pkg::cmd_word_t cmd_data;
   logic               cmd_rts;
   logic               cmd_rtr;
   logic               rsp_rtr;
   cmd_pkg::cmd_word_t rsp_data;
   logic               rsp_rts;

   int          tnum [MAX_RECS];                 // Test number per record
   logic [31:0] cmds [MAX_RECS];                 // Command words
   logic [31:0] exps [MAX_RECS];                 // Expected response words
   int          n_recs;
   int          test_err [16];                   // Mismatches per test
   int          pass_cnt;
   int          fail_cnt;
   int          extra_err;                       // Responses beyond the trace
   int          rsp_idx;                         // Next expected response
   int          cycles;
   int          limit;
   integer      seed;
   logic        started;                         // Reset done, traffic may start
   logic        hold_rsp;                        // Response side stalled for test 5
   logic        full_seen;                       // cmd_rtr dropped during the stall
   logic        pop_pend;                        // Response word due after this edge
   logic        timed_out;

   cmd_proc_top DUT (
      .clk(clk), .rst_n(rst_n),
      .cmd_data(cmd_data), .cmd_rts(cmd_rts), .cmd_rtr(cmd_rtr),
      .rsp_rtr(rsp_rtr), .rsp_data(rsp_data), .rsp_rts(rsp_rts)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;                    // 40 ns period
   end

   always @(posedge clk)
      cycles <= cycles + 1;

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp, input int test_id);
      if (got !== exp)
      begin
         $display("** Error %s: got %h, expected %h (test %0d)", name, got, exp, test_id);
         test_err[test_id]++;
      end
   endtask

   // One line per finished test
   task automatic report_test(input int test_id);
      if (test_id == 5 && !full_seen)
      begin
         $display("Test 5: cmd_rtr never dropped while the response queue was held");
         test_err[5]++;
      end
      if (test_err[test_id] == 0)
      begin
         $display("Test %0d: PASS", test_id);
         pass_cnt++;
      end
      else
      begin
         $display("Test %0d: FAIL, %0d errors", test_id, test_err[test_id]);
         fail_cnt++;
      end
   endtask

   // Last record of its test number
   function automatic logic is_last(input int i);
      return (i == n_recs - 1) || (tnum[i+1] != tnum[i]);
   endfunction

   task automatic load_trace;
      int          fd;
      int          t;
      logic [31:0] c;
      logic [31:0] e;
      string       line;
      fd = $fopen("tests/cmd_trace.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the trace file tests/cmd_trace.txt");
         fail_cnt++;
         return;
      end
      while (!$feof(fd) && n_recs < MAX_RECS)
      begin
         line = "";
         void'($fgets(line, fd));
         if ($sscanf(line, "%d %h %h", t, c, e) == 3)   // Comment lines fail the parse
         begin
            tnum[n_recs] = t;
            cmds[n_recs] = c;
            exps[n_recs] = e;
            n_recs++;
         end
      end
      $fclose(fd);
   endtask

   task automatic take_response;
      if (rsp_idx >= n_recs)
      begin
         $display("Unexpected response word %h after the end of the trace", rsp_data);
         extra_err++;
      end
      else
      begin
         check_val("rsp_data", rsp_data, exps[rsp_idx], tnum[rsp_idx]);
         if (is_last(rsp_idx))
            report_test(tnum[rsp_idx]);
         rsp_idx++;
      end
   endtask

   // Command sender, each word held until the queue takes it
   initial
   begin
      wait (started);
      @(posedge clk);
      for (int i = 0; i < n_recs; i++)
      begin
         if (tnum[i] == 5 && (i == 0 || tnum[i-1] != 5))
            hold_rsp = 1'b1;                     // Full queue test starts here
         cmd_data <= cmds[i];
         cmd_rts  <= 1'b1;
         @(negedge clk);
         while (!cmd_rtr)
            @(negedge clk);
         @(posedge clk);                         // Word enters the command queue
         if (tnum[i] == 5 && is_last(i))
            hold_rsp = 1'b0;
      end
      cmd_rts <= 1'b0;
   end

   // Random back-pressure, decided at the falling edge and driven at the rising one
   initial
   begin
      logic next_rtr;
      wait (started);
      forever
      begin
         @(negedge clk);
         if (hold_rsp && cmd_rts && !cmd_rtr)
         begin
            full_seen = 1'b1;                    // Queues and stages all full
            hold_rsp  = 1'b0;
         end
         next_rtr = ($unsigned($random(seed)) % 32'd10) < 32'd6;   // About 60% ready
         if (hold_rsp)
            next_rtr = 1'b0;
         @(posedge clk);
         rsp_rtr <= next_rtr;
      end
   end

   // Response monitor, word is on rsp_data one cycle after its pop
   initial
   begin
      forever
      begin
         @(negedge clk);
         if (pop_pend)
            take_response();
         pop_pend = rst_n && rsp_rts && rsp_rtr;
      end
   end

   initial
   begin
      rst_n     = 1'b0;
      cmd_data  = '0;
      cmd_rts   = 1'b0;
      rsp_rtr   = 1'b0;
      seed      = 47;
      cycles    = 0;
      n_recs    = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      extra_err = 0;
      rsp_idx   = 0;
      started   = 1'b0;
      hold_rsp  = 1'b0;
      full_seen = 1'b0;
      pop_pend  = 1'b0;
      timed_out = 1'b0;
      for (int k = 0; k < 16; k++)
         test_err[k] = 0;
      load_trace();
      limit = 40 * n_recs + 200;                 // Cycle budget for the whole trace
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_val("cmd_rtr", 32'(cmd_rtr), 32'h1, 1);
      check_val("rsp_rts", 32'(rsp_rts), 32'h0, 1);
      report_test(1);
      started = 1'b1;
      while (rsp_idx < n_recs && cycles < limit)
         @(negedge clk);
      timed_out = (rsp_idx < n_recs);
      if (timed_out)
         $display("Timeout after %0d cycles, %0d of %0d responses received",
                  cycles, rsp_idx, n_recs);
      else
         repeat (20) @(negedge clk);             // Window for stray responses
      $display("Summary: %0d tests PASS, %0d tests FAIL, %0d extra words",
               pass_cnt, fail_cnt, extra_err);
      if (!timed_out && fail_cnt == 0 && extra_err == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// File: tests/cmd_trace.txt
# test  command   expected response, all words in hex
# Test 1 (reset state) is checked without trace records
2 00001234 00001234
2 0400FF0F 0400FF0F
2 1000F000 10020234
2 20000234 20010000
2 20000001 2002FFFF
2 31000000 3000FF0F
2 49000000 4800FF0F
2 58000000 58010000
2 0C008001 0C008001
2 6C000001 6C020002
2 6C000004 6C000020
2 70000000 7000FF0F
2 78000000 78010000
3 94005555 94050000
3 F000FFFF F0050000
3 74000000 7400FF0F
3 70000000 7000FF0F
4 080000FF 080000FF
4 18000001 18000100
4 59000000 5800FE0F
4 2800FE0F 28010000
4 7C000000 7C000020
5 00000000 00010000
5 10000001 10000001
5 10000001 10000002
5 10000001 10000003
5 10000001 10000004
5 10000001 10000005
5 10000001 10000006
5 10000001 10000007
5 10000001 10000008
5 10000001 10000009
5 10000001 1000000A
5 10000001 1000000B
5 10000001 1000000C
5 10000001 1000000D
5 10000001 1000000E
5 10000001 1000000F
5 10000001 10000010
5 10000001 10000011
5 10000001 10000012
5 70000000 70000012

// File: src.f
+incdir+verilog
verilog/cmd_pkg.sv
verilog/fifo.sv
verilog/cmd_decode.sv
verilog/alu_execute.sv
verilog/result_pack.sv
verilog/cmd_proc_top.sv
tests/cmd_proc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the command processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module cmd_proc_tb -Mdir obj_dir
./obj_dir/Vcmd_proc_tb | tee sim.log

if grep -q "test failed" sim.log
then
   echo "Simulation FAILED"
   exit 1
fi
echo "Simulation finished without failures"
